/* verilog/gpu_regfile_pkg.sv */
//----------------------------------------
// Shared sizes, types and the arbiter
// state encoding for the operand stage
//----------------------------------------
`default_nettype none

package gpu_regfile_pkg;

  // Sizes fixed by the register numbering
  localparam int bank_num   = 4;  // Bank picked by register bits 4 and 3
  localparam int reg_count  = 32; // Registers per warp
  localparam int src_slots  = 3;  // Source operands per instruction
  localparam int data_width = 32;
  localparam int tag_width  = 8;

  // Register number, bits [4:3] select the bank and bits [2:0] the row
  typedef logic [4:0] reg_num_t;

  // Bank index and row within a bank for one warp
  typedef logic [1:0] bank_idx_t;
  typedef logic [2:0] row_t;

  // Operand slot inside a collector entry
  typedef logic [1:0] slot_num_t;

  // One register value
  typedef logic [data_width-1:0] word_t;

  // Instruction tag carried from issue to dispatch
  typedef logic [tag_width-1:0] tag_t;

  // Arbiter round sequencing
  typedef enum logic [1:0] {
    arb_idle,
    arb_read,
    arb_respond
  } arb_state_t;

endpackage

`default_nettype wire

/* verilog/collect_request_if.sv */
//----------------------------------------
// Pending operand requests, driven by the
// collector and sampled by the arbiter
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface collect_request_if #(
  parameter int collector_size = 2,
  parameter int warp_count     = 4
);
  import gpu_regfile_pkg::*;

  localparam int warp_w = (warp_count > 1) ? $clog2(warp_count) : 1;

  logic                                         valid;       // Level while operands are missing
  logic [collector_size-1:0]                    entry_valid;
  logic [collector_size-1:0][src_slots-1:0]     reg_valid;   // Operand still needed
  reg_num_t [collector_size-1:0][src_slots-1:0] reg_num;
  logic [collector_size-1:0][warp_w-1:0]        warp;

  modport collector (
    output valid, entry_valid, reg_valid, reg_num, warp
  );

  modport arbiter (
    input valid, entry_valid, reg_valid, reg_num, warp
  );

endinterface

`default_nettype wire

/* verilog/collect_response_if.sv */
//----------------------------------------
// Bank read results returned by the
// arbiter to the collector entries
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface collect_response_if #(
  parameter int collector_size = 2
);
  import gpu_regfile_pkg::*;

  localparam int idx_w = (collector_size > 1) ? $clog2(collector_size) : 1;

  logic                             valid;      // One cycle pulse per round
  logic [bank_num-1:0]              data_valid; // Bank carries a granted operand
  word_t [bank_num-1:0]             data;
  logic [bank_num-1:0][idx_w-1:0]   entry;      // Target collector entry
  slot_num_t [bank_num-1:0]         slot;       // Target operand slot

  modport arbiter (
    output valid, data_valid, data, entry, slot
  );

  modport collector (
    input valid, data_valid, data, entry, slot
  );

endinterface

`default_nettype wire

/* verilog/bank_access_if.sv */
//----------------------------------------
// Per bank read address from the arbiter
// and combinational read data back
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

interface bank_access_if #(
  parameter int warp_count = 4
);
  import gpu_regfile_pkg::*;

  localparam int warp_w = (warp_count > 1) ? $clog2(warp_count) : 1;

  reg_num_t [bank_num-1:0]         reg_num;
  logic [bank_num-1:0][warp_w-1:0] warp;
  word_t [bank_num-1:0]            data;    // Valid in the same cycle

  modport arbiter (output reg_num, warp, input data);
  modport banks (input reg_num, warp, output data);

endinterface

`default_nettype wire

/* verilog/register_file_arbiter.sv */
//----------------------------------------
// Grants each bank to one pending operand
// per round, reads it and answers the
// collector three cycles after accepting
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module register_file_arbiter #(
  parameter int collector_size = 2,
  parameter int warp_count     = 4
) (
  input  wire logic                clk,
  input  wire logic                rst_n,
  collect_request_if.arbiter       request,
  bank_access_if.arbiter           banks,
  collect_response_if.arbiter      response
);
  import gpu_regfile_pkg::*;

  localparam int idx_w  = (collector_size > 1) ? $clog2(collector_size) : 1;
  localparam int warp_w = (warp_count > 1) ? $clog2(warp_count) : 1;

  arb_state_t                      state;
  logic                            resp_valid;
  logic                            accept;

  // Combinational choice for the current request picture
  logic [bank_num-1:0]                                pick_valid;
  reg_num_t [bank_num-1:0]                            pick_reg;
  logic [bank_num-1:0][warp_w-1:0]                    pick_warp;
  logic [bank_num-1:0][idx_w-1:0]                     pick_entry;
  slot_num_t [bank_num-1:0]                           pick_slot;

  // Latched round
  logic [bank_num-1:0]             grant_q;
  reg_num_t [bank_num-1:0]         reg_q;
  logic [bank_num-1:0][warp_w-1:0] warp_q;
  logic [bank_num-1:0][idx_w-1:0]  entry_q;
  slot_num_t [bank_num-1:0]        slot_q;
  word_t [bank_num-1:0]            data_q;

  // Collector slots filled by the latched round, per register bank
  logic [bank_num-1:0][collector_size*src_slots-1:0]  bank_hits;

  // Collector updates on the pulse edge, so wait one more cycle
  assign accept = (state == arb_idle) && request.valid && !resp_valid;

  // Entry order first, then slot order; a taken bank is skipped
  always_comb begin
    bank_idx_t b;
    b          = '0;
    pick_valid = '0;
    pick_reg   = '0;
    pick_warp  = '0;
    pick_entry = '0;
    pick_slot  = '0;
    for (int i = 0; i < collector_size; i++) begin
      for (int j = 0; j < src_slots; j++) begin
        b = request.reg_num[i][j][4:3];
        if (request.entry_valid[i] && request.reg_valid[i][j] && !pick_valid[b]) begin
          pick_valid[b] = 1'b1;
          pick_reg[b]   = request.reg_num[i][j];
          pick_warp[b]  = request.warp[i];
          pick_entry[b] = idx_w'(i);
          pick_slot[b]  = slot_num_t'(j);
        end
      end
    end
  end

  // Slots named by the response lanes, sorted by the bank of their register
  always_comb begin
    bank_hits = '0;
    for (int i = 0; i < collector_size; i++) begin
      for (int j = 0; j < src_slots; j++) begin
        for (int l = 0; l < bank_num; l++) begin
          if (grant_q[l] && (entry_q[l] == idx_w'(i)) && (slot_q[l] == slot_num_t'(j)))
            bank_hits[request.reg_num[i][j][4:3]][i*src_slots+j] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= arb_idle;
      resp_valid <= 1'b0;
      grant_q    <= '0;
    end else begin
      resp_valid <= 1'b0;
      case (state)
        arb_idle: begin
          if (accept) begin
            grant_q <= pick_valid;
            state   <= arb_read;
          end
        end
        arb_read:    state <= arb_respond;
        arb_respond: begin
          resp_valid <= 1'b1; // Seen by the collector on the next edge
          state      <= arb_idle;
        end
        default:     state <= arb_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      reg_q   <= pick_reg;
      warp_q  <= pick_warp;
      entry_q <= pick_entry;
      slot_q  <= pick_slot;
    end
    if (state == arb_read) data_q <= banks.data;
  end

  assign banks.reg_num       = reg_q;
  assign banks.warp          = warp_q;

  assign response.valid      = resp_valid;
  assign response.data_valid = grant_q;
  assign response.data       = data_q;
  assign response.entry      = entry_q;
  assign response.slot       = slot_q;

  a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    response.valid |=> !response.valid);

  for (genvar gb = 0; gb < bank_num; gb++) begin : g_bank_chk
    a_one_per_bank: assert property (@(posedge clk) disable iff (!rst_n)
      response.valid |-> $onehot0(bank_hits[gb]));
  end

endmodule

`default_nettype wire

/* verilog/register_bank_array.sv */
//----------------------------------------
// Four register banks indexed by warp and
// row, read per bank, one writeback port
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module register_bank_array #(
  parameter int warp_count = 4,
  localparam int warp_w    = (warp_count > 1) ? $clog2(warp_count) : 1
) (
  input  wire logic                      clk,
  input  wire logic                      rst_n,
  bank_access_if.banks                   banks,
  input  wire logic                      wb_valid,
  input  wire logic [warp_w-1:0]         wb_warp,
  input  wire gpu_regfile_pkg::reg_num_t wb_reg,
  input  wire gpu_regfile_pkg::word_t    wb_data
);
  import gpu_regfile_pkg::*;

  localparam int rows = reg_count / bank_num; // Rows per warp in one bank

  word_t     mem [bank_num][warp_count][rows];
  bank_idx_t wb_bank;
  row_t      wb_row;

  assign wb_bank = wb_reg[4:3];
  assign wb_row  = wb_reg[2:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < bank_num; b++) begin
        for (int w = 0; w < warp_count; w++) begin
          for (int r = 0; r < rows; r++) begin
            mem[b][w][r] <= '0;
          end
        end
      end
    end else if (wb_valid) begin
      mem[wb_bank][wb_warp][wb_row] <= wb_data;
    end
  end

  // Writeback wins over the stored word in the same cycle
  for (genvar gb = 0; gb < bank_num; gb++) begin : g_read
    row_t rd_row;
    logic bypass;

    assign rd_row = banks.reg_num[gb][2:0];
    assign bypass = wb_valid && (wb_warp == banks.warp[gb]) &&
                    (wb_reg == banks.reg_num[gb]);

    assign banks.data[gb] = bypass ? wb_data : mem[gb][banks.warp[gb]][rd_row];
  end

  a_wb_warp_range: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> (int'(wb_warp) < warp_count));

endmodule

`default_nettype wire

/* verilog/operand_collector.sv */
//----------------------------------------
// Collector entries: take issued
// instructions, gather operands from bank
// responses and dispatch complete ones
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module operand_collector #(
  parameter int collector_size = 2,
  parameter int warp_count     = 4,
  localparam int warp_w        = (warp_count > 1) ? $clog2(warp_count) : 1
) (
  input  wire logic                                                    clk,
  input  wire logic                                                    rst_n,
  input  wire logic                                                    issue_valid,
  input  wire logic [warp_w-1:0]                                       issue_warp,
  input  wire gpu_regfile_pkg::reg_num_t [gpu_regfile_pkg::src_slots-1:0] issue_src,
  input  wire logic [gpu_regfile_pkg::src_slots-1:0]                   issue_src_used,
  input  wire gpu_regfile_pkg::tag_t                                   issue_tag,
  output logic                                                         issue_ready,
  output logic                                                         dispatch_valid,
  output gpu_regfile_pkg::tag_t                                        dispatch_tag,
  output gpu_regfile_pkg::word_t [gpu_regfile_pkg::src_slots-1:0]      dispatch_operands,
  collect_request_if.collector                                         request,
  collect_response_if.collector                                        response
);
  import gpu_regfile_pkg::*;

  localparam int idx_w = (collector_size > 1) ? $clog2(collector_size) : 1;

  logic [collector_size-1:0]                    ent_valid;
  logic [collector_size-1:0][src_slots-1:0]     pending;   // Operand not yet returned
  logic [collector_size-1:0][warp_w-1:0]        ent_warp;
  tag_t [collector_size-1:0]                    ent_tag;
  reg_num_t [collector_size-1:0][src_slots-1:0] ent_reg;
  word_t [src_slots-1:0]                        ent_data [collector_size];

  logic [collector_size-1:0]                    complete;
  logic [idx_w-1:0]                             free_idx;
  logic [idx_w-1:0]                             done_idx;
  logic                                         issue_fire;

  // Lowest free and lowest complete entry
  always_comb begin
    free_idx = '0;
    done_idx = '0;
    for (int i = collector_size - 1; i >= 0; i--) begin
      complete[i] = ent_valid[i] && (pending[i] == '0);
      if (!ent_valid[i]) free_idx = idx_w'(i);
      if (complete[i])   done_idx = idx_w'(i);
    end
  end

  assign issue_ready = ~&ent_valid;
  assign issue_fire  = issue_valid && issue_ready;

  always_comb begin
    request.valid = 1'b0;
    for (int i = 0; i < collector_size; i++) begin
      request.valid = request.valid | (ent_valid[i] && (pending[i] != '0));
    end
  end

  assign request.entry_valid = ent_valid;
  assign request.reg_valid   = pending;
  assign request.reg_num     = ent_reg;
  assign request.warp        = ent_warp;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ent_valid      <= '0;
      pending        <= '0;
      dispatch_valid <= 1'b0;
    end else begin
      dispatch_valid <= |complete;
      if (|complete) ent_valid[done_idx] <= 1'b0;
      if (issue_fire) begin
        ent_valid[free_idx] <= 1'b1;
        pending[free_idx]   <= issue_src_used;
      end
      for (int b = 0; b < bank_num; b++) begin
        if (response.valid && response.data_valid[b])
          pending[response.entry[b]][response.slot[b]] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (issue_fire) begin
      ent_warp[free_idx] <= issue_warp;
      ent_tag[free_idx]  <= issue_tag;
      ent_reg[free_idx]  <= issue_src;
      ent_data[free_idx] <= '0; // Unused slots leave as zero
    end
    for (int b = 0; b < bank_num; b++) begin
      if (response.valid && response.data_valid[b])
        ent_data[response.entry[b]][response.slot[b]] <= response.data[b];
    end
    if (|complete) begin
      dispatch_tag      <= ent_tag[done_idx];
      dispatch_operands <= ent_data[done_idx];
    end
  end

  for (genvar gb = 0; gb < bank_num; gb++) begin : g_resp_chk
    a_resp_pending: assert property (@(posedge clk) disable iff (!rst_n)
      (response.valid && response.data_valid[gb]) |->
        pending[response.entry[gb]][response.slot[gb]]);
  end

endmodule

`default_nettype wire

/* verilog/operand_stage_top.sv */
//----------------------------------------
// Operand collection stage: collector,
// bank arbiter and register banks
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module operand_stage_top #(
  parameter int collector_size = 2,
  parameter int warp_count     = 4,
  localparam int warp_w        = (warp_count > 1) ? $clog2(warp_count) : 1
) (
  input  wire logic                                                    clk,
  input  wire logic                                                    rst_n,
  // Issue side
  input  wire logic                                                    issue_valid,
  input  wire logic [warp_w-1:0]                                       issue_warp,
  input  wire gpu_regfile_pkg::reg_num_t [gpu_regfile_pkg::src_slots-1:0] issue_src,
  input  wire logic [gpu_regfile_pkg::src_slots-1:0]                   issue_src_used,
  input  wire gpu_regfile_pkg::tag_t                                   issue_tag,
  output logic                                                         issue_ready,
  // Writeback into the banks
  input  wire logic                                                    wb_valid,
  input  wire logic [warp_w-1:0]                                       wb_warp,
  input  wire gpu_regfile_pkg::reg_num_t                               wb_reg,
  input  wire gpu_regfile_pkg::word_t                                  wb_data,
  // Dispatch side, always accepted
  output logic                                                         dispatch_valid,
  output gpu_regfile_pkg::tag_t                                        dispatch_tag,
  output gpu_regfile_pkg::word_t [gpu_regfile_pkg::src_slots-1:0]      dispatch_operands
);

  collect_request_if #(
    .collector_size (collector_size),
    .warp_count     (warp_count)
  ) req_if ();

  collect_response_if #(
    .collector_size (collector_size)
  ) resp_if ();

  bank_access_if #(
    .warp_count (warp_count)
  ) bank_if ();

  operand_collector #(
    .collector_size (collector_size),
    .warp_count     (warp_count)
  ) collector0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid       (issue_valid),
    .issue_warp        (issue_warp),
    .issue_src         (issue_src),
    .issue_src_used    (issue_src_used),
    .issue_tag         (issue_tag),
    .issue_ready       (issue_ready),
    .dispatch_valid    (dispatch_valid),
    .dispatch_tag      (dispatch_tag),
    .dispatch_operands (dispatch_operands),
    .request           (req_if.collector),
    .response          (resp_if.collector)
  );

  register_file_arbiter #(
    .collector_size (collector_size),
    .warp_count     (warp_count)
  ) arbiter0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .request  (req_if.arbiter),
    .banks    (bank_if.arbiter),
    .response (resp_if.arbiter)
  );

  register_bank_array #(
    .warp_count (warp_count)
  ) banks0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .banks    (bank_if.banks),
    .wb_valid (wb_valid),
    .wb_warp  (wb_warp),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data)
  );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
//----------------------------------------
// Testbench clock and reset source, holds
// rst_n low for a set number of cycles
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module clock_gen #(
  parameter real period       = 20.0,
  parameter int  reset_cycles = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk   = 1'b0;
    rst_n = 1'b0;
    forever #(period / 2.0) clk = ~clk;
  end

  initial begin
    repeat (reset_cycles) @(posedge clk);
    #2;
    rst_n = 1'b1; // Released off the edge like the other inputs
  end

endmodule

`default_nettype wire

/* bench/operand_stage_tb.sv */
//----------------------------------------
// Testbench for the operand stage: fills
// the banks, issues a table of instructions
// and checks each dispatch against a model
//----------------------------------------
`timescale 1ns/10ps
`default_nettype none

module operand_stage_tb;
  import gpu_regfile_pkg::*;

  localparam int collector_size = 2;
  localparam int warp_count     = 4;
  localparam int warp_w         = 2;
  localparam int reset_cycles   = 10;
  localparam int row_count      = 12;
  localparam int timeout_cycles = reset_cycles + warp_count * reg_count + 64 * row_count;

  typedef struct packed {
    logic              wb_first; // Drain, then rewrite src0 before issue
    logic [warp_w-1:0] warp;
    reg_num_t          src0;
    reg_num_t          src1;
    reg_num_t          src2;
    logic [2:0]        used;
    tag_t              tag;
  } instr_row_t;

  // Banks are reg bits 4:3, so r1/r9/r17 differ and r3/r4/r5 collide
  localparam instr_row_t table_rows [row_count] = '{
    '{1'b0, 2'd0, 5'd1,  5'd9,  5'd17, 3'b111, 8'h10},
    '{1'b0, 2'd1, 5'd2,  5'd10, 5'd26, 3'b111, 8'h11},
    '{1'b0, 2'd2, 5'd3,  5'd4,  5'd5,  3'b111, 8'h12},
    '{1'b0, 2'd3, 5'd8,  5'd12, 5'd15, 3'b111, 8'h13},
    '{1'b0, 2'd0, 5'd20, 5'd0,  5'd31, 3'b101, 8'h14},
    '{1'b0, 2'd1, 5'd0,  5'd0,  5'd0,  3'b000, 8'h15},
    '{1'b0, 2'd2, 5'd7,  5'd7,  5'd7,  3'b111, 8'h16},
    '{1'b0, 2'd3, 5'd24, 5'd16, 5'd9,  3'b010, 8'h17},
    '{1'b1, 2'd1, 5'd13, 5'd2,  5'd30, 3'b111, 8'h18},
    '{1'b1, 2'd2, 5'd25, 5'd25, 5'd1,  3'b011, 8'h19},
    '{1'b0, 2'd1, 5'd13, 5'd6,  5'd22, 3'b111, 8'h1a},
    '{1'b0, 2'd3, 5'd31, 5'd23, 5'd15, 3'b111, 8'h1b}
  };

  logic                    clk;
  logic                    rst_n;
  logic                    issue_valid;
  logic [warp_w-1:0]       issue_warp;
  reg_num_t [src_slots-1:0] issue_src;
  logic [src_slots-1:0]    issue_src_used;
  tag_t                    issue_tag;
  logic                    issue_ready;
  logic                    wb_valid;
  logic [warp_w-1:0]       wb_warp;
  reg_num_t                wb_reg;
  word_t                   wb_data;
  logic                    dispatch_valid;
  tag_t                    dispatch_tag;
  word_t [src_slots-1:0]   dispatch_operands;

  word_t model [warp_count][reg_count]; // Current register contents
  word_t exp_ops [row_count][src_slots]; // Captured at issue
  int    seen [row_count];
  int    issued_count     = 0;
  int    dispatched_count = 0;
  int    cycle_count      = 0;

  clock_gen #(.period(20.0), .reset_cycles(reset_cycles)) clk0 (.clk(clk), .rst_n(rst_n));

  operand_stage_top #(
    .collector_size (collector_size),
    .warp_count     (warp_count)
  ) dut0 (
    .clk               (clk),
    .rst_n             (rst_n),
    .issue_valid       (issue_valid),
    .issue_warp        (issue_warp),
    .issue_src         (issue_src),
    .issue_src_used    (issue_src_used),
    .issue_tag         (issue_tag),
    .issue_ready       (issue_ready),
    .wb_valid          (wb_valid),
    .wb_warp           (wb_warp),
    .wb_reg            (wb_reg),
    .wb_data           (wb_data),
    .dispatch_valid    (dispatch_valid),
    .dispatch_tag      (dispatch_tag),
    .dispatch_operands (dispatch_operands)
  );

  task automatic stop_run(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
      stop_run($sformatf("ERROR: time %0t: %s: got %h, expected %h",
                         $time, what, got, expected));
  endtask

  function automatic int find_row(input tag_t tag);
    int idx;
    idx = -1;
    for (int i = 0; i < row_count; i++) begin
      if (table_rows[i].tag == tag) idx = i;
    end
    return idx;
  endfunction

  // Called 2 ns after an edge; returns 2 ns after the write edge
  task automatic write_reg(input logic [warp_w-1:0] w, input reg_num_t r, input word_t d);
    wb_valid = 1'b1;
    wb_warp  = w;
    wb_reg   = r;
    wb_data  = d;
    model[w][r] = d;
    @(posedge clk);
    #2;
    wb_valid = 1'b0;
  endtask

  task automatic issue_instr(input int idx);
    instr_row_t row;
    reg_num_t   srcs [src_slots];
    row = table_rows[idx];
    srcs[0] = row.src0;
    srcs[1] = row.src1;
    srcs[2] = row.src2;
    while (!issue_ready) begin
      @(posedge clk);
      #2;
    end
    issue_valid    = 1'b1;
    issue_warp     = row.warp;
    issue_src      = {row.src2, row.src1, row.src0};
    issue_src_used = row.used;
    issue_tag      = row.tag;
    for (int k = 0; k < src_slots; k++) begin
      exp_ops[idx][k] = row.used[k] ? model[row.warp][srcs[k]] : '0; // Unused reads zero
    end
    issued_count++;
    @(posedge clk);
    #2;
    issue_valid = 1'b0;
  endtask

  task automatic wait_drained();
    while (dispatched_count != issued_count) begin
      @(posedge clk);
      #2;
    end
  endtask

  // Outputs are registered, so they are settled by the falling edge
  always @(negedge clk) begin
    int idx;
    if (rst_n && dispatch_valid) begin
      idx = find_row(dispatch_tag);
      if (idx < 0)
        stop_run($sformatf("Dispatch carried tag %h, which was never issued", dispatch_tag));
      seen[idx]++;
      if (seen[idx] > 1)
        stop_run($sformatf("Tag %h was dispatched more than once", dispatch_tag));
      for (int k = 0; k < src_slots; k++) begin
        check_value($sformatf("tag %h operand %0d", dispatch_tag, k),
                    dispatch_operands[k], exp_ops[idx][k]);
      end
      dispatched_count++;
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > timeout_cycles)
      stop_run($sformatf("Run did not finish within %0d cycles", timeout_cycles));
  end

  initial begin
    int missing;
    missing        = 0;
    issue_valid    = 1'b0;
    issue_warp     = '0;
    issue_src      = '0;
    issue_src_used = '0;
    issue_tag      = '0;
    wb_valid       = 1'b0;
    wb_warp        = '0;
    wb_reg         = '0;
    wb_data        = '0;
    for (int i = 0; i < row_count; i++) seen[i] = 0;
    void'($urandom(32'ha6cb));

    @(posedge rst_n);
    @(posedge clk);
    #2;
    check_value("dispatch_valid after reset", 32'(dispatch_valid), 32'd0);
    check_value("issue_ready after reset", 32'(issue_ready), 32'd1);

    // Fill every register of every warp
    for (int w = 0; w < warp_count; w++) begin
      for (int r = 0; r < reg_count; r++) begin
        write_reg(warp_w'(w), reg_num_t'(r), $urandom());
      end
    end

    for (int i = 0; i < row_count; i++) begin
      if (table_rows[i].wb_first) begin
        wait_drained(); // Earlier reads must not see the new value
        write_reg(table_rows[i].warp, table_rows[i].src0, $urandom());
      end
      issue_instr(i);
    end

    wait_drained();
    repeat (8) @(posedge clk); // Room for any stray dispatch

    for (int i = 0; i < row_count; i++) begin
      if (seen[i] != 1) missing++;
    end
    if (missing == 0) begin
      $display("STATUS: PASS");
      $finish;
    end else begin
      stop_run($sformatf("%0d table rows were not dispatched exactly once", missing));
    end
  end

endmodule

`default_nettype wire

/* tb.f */
verilog/gpu_regfile_pkg.sv
verilog/collect_request_if.sv
verilog/collect_response_if.sv
verilog/bank_access_if.sv
verilog/register_file_arbiter.sv
verilog/register_bank_array.sv
verilog/operand_collector.sv
verilog/operand_stage_top.sv
bench/clock_gen.sv
bench/operand_stage_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the operand stage testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  --top-module operand_stage_tb \
  -f tb.f \
  --Mdir obj_dir

./obj_dir/Voperand_stage_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: PASS" sim.log; then
  exit 0
else
  exit 1
fi
